// File: run.sh
#!/bin/sh
# build the decoder testbench with verilator, run it and check the log
rm -rf obj_dir build.log sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_instr_decoder -f tb.f \
  -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_instr_decoder > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "TEST PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: tb.f
verilog/decoder_pkg.sv
verilog/ctrl_flow_decoder.sv
verilog/lsu_decoder.sv
verilog/alu_decoder.sv
verilog/csr_decoder.sv
verilog/instr_decoder.sv
verification/decoder_checks.sv
verification/tb_instr_decoder.sv

// File: verification/decoder_checks.sv
// reference decoder rules for the rv32im decoder ports
// concurrent assertions against the rules, mismatch counter
module decoder_checks
  import decoder_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  logic               first_cycle_i,
  input  logic               illegal_c_i,
  input  logic               illegal_insn_i,
  input  logic               rf_we_i, data_req_i, data_we_i, jump_in_dec_i,
  input  logic               jump_set_i, branch_in_dec_i, csr_access_i,
  input  logic               rf_ren_a_i, rf_ren_b_i,
  input  logic               ecall_i, ebrk_i, mret_i, dret_i, wfi_i,
  input  logic               icache_inval_i,
  input  logic [1:0]         data_type_i,
  input  logic               data_sign_ext_i,
  input  md_op_e             md_op_i,
  input  logic [1:0]         md_signed_i,
  input  csr_op_e            csr_op_i,
  input  rf_wd_sel_e         wdata_sel_i,
  output int                 err_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [6:0] op;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [4:0] rs1;
  logic [4:0] rd;
  logic       known;
  logic       bad;
  logic       exp_illegal;
  logic       e_rf_we, e_req, e_we, e_jump, e_jset, e_branch, e_csr;
  logic [6:0] exp_side;
  logic [6:0] side;
  logic [4:0] exp_sys;   // ecall, ebreak, mret, dret, wfi
  logic [4:0] sys;
  logic       exp_icache;
  logic       exp_ren_a;
  logic       exp_ren_b;
  logic [1:0] exp_type;
  logic       exp_sext;
  md_op_e     exp_md;
  logic [1:0] exp_msign;
  csr_op_e    exp_csr_op;
  rf_wd_sel_e exp_wsel;
  int         errors = 0;

  assign op   = instr_i[6:0];
  assign f3   = instr_i[14:12];
  assign f7   = instr_i[31:25];
  assign rs1  = instr_i[19:15];
  assign rd   = instr_i[11:7];
  assign side = {rf_we_i, data_req_i, data_we_i, jump_in_dec_i, jump_set_i,
                 branch_in_dec_i, csr_access_i};
  assign sys  = {ecall_i, ebrk_i, mret_i, dret_i, wfi_i};
  assign err_count_o = errors;

  //////////////////////////////
  // reference rules
  //////////////////////////////
  always_comb begin
    known      = 1'b1;
    bad        = 1'b0;
    {e_rf_we, e_req, e_we, e_jump, e_jset, e_branch, e_csr} = '0;
    exp_sys    = '0;
    exp_icache = 1'b0;
    exp_ren_a  = 1'b0;
    exp_ren_b  = 1'b0;
    exp_type   = DATA_TYPE_WORD;
    exp_sext   = 1'b0;
    exp_md     = MD_OP_MULL;
    exp_msign  = MD_SIGNED_NONE;
    exp_csr_op = CSR_OP_READ;
    exp_wsel   = RF_WD_EX;
    case (op)
      OPCODE_LOAD, OPCODE_STORE: begin
        e_req     = 1'b1;
        e_we      = (op == OPCODE_STORE);
        e_rf_we   = (op == OPCODE_LOAD);
        exp_ren_a = 1'b1;                  // base address
        exp_ren_b = (op == OPCODE_STORE);  // store data
        exp_sext  = (op == OPCODE_LOAD) && !f3[2];
        case (f3[1:0])
          2'd0:    exp_type = DATA_TYPE_BYTE;
          2'd1:    exp_type = DATA_TYPE_HALF;
          2'd2:    exp_type = DATA_TYPE_WORD;
          default: bad = 1'b1;
        endcase
        if (e_we && f3[2]) begin
          bad = 1'b1;
        end
        if (e_rf_we && f3 == 3'd6) begin
          bad = 1'b1;  // lwu
        end
      end
      OPCODE_MISC_MEM: begin
        if (f3 == 3'd1) begin
          e_jump     = 1'b1;
          e_jset     = first_cycle_i;
          exp_icache = first_cycle_i;
        end else if (f3 != 3'd0) begin
          bad = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        e_rf_we   = 1'b1;
        exp_ren_a = 1'b1;
        if (f3 == 3'd1 && f7 != FUNCT7_BASE) begin
          bad = 1'b1;
        end
        if (f3 == 3'd5 && !(f7 inside {FUNCT7_BASE, FUNCT7_ALT})) begin
          bad = 1'b1;
        end
      end
      OPCODE_LUI, OPCODE_AUIPC: e_rf_we = 1'b1;
      OPCODE_OP: begin
        e_rf_we   = 1'b1;
        exp_ren_a = 1'b1;
        exp_ren_b = 1'b1;
        if (f7 == FUNCT7_MULDIV) begin
          case (f3)
            3'd0:             exp_md = MD_OP_MULL;
            3'd1, 3'd2, 3'd3: exp_md = MD_OP_MULH;
            3'd4, 3'd5:       exp_md = MD_OP_DIV;
            default:          exp_md = MD_OP_REM;
          endcase
          if (f3 == 3'd2) begin
            exp_msign = MD_SIGNED_MIXED;  // mulhsu
          end else if (f3 inside {3'd1, 3'd4, 3'd6}) begin
            exp_msign = MD_SIGNED_BOTH;
          end
        end else if (f7 == FUNCT7_ALT) begin
          bad = !(f3 inside {3'd0, 3'd5});  // only sub and sra
        end else if (f7 != FUNCT7_BASE) begin
          bad = 1'b1;
        end
      end
      OPCODE_BRANCH: begin
        e_branch  = 1'b1;
        exp_ren_a = 1'b1;
        exp_ren_b = 1'b1;
        bad       = (f3 inside {3'd2, 3'd3});
      end
      OPCODE_JAL, OPCODE_JALR: begin
        e_jump    = 1'b1;
        e_jset    = first_cycle_i;
        e_rf_we   = 1'b1;
        exp_ren_a = (op == OPCODE_JALR);  // jal has no register operand
        bad       = (op == OPCODE_JALR) && (f3 != 3'd0);
      end
      OPCODE_SYSTEM: begin
        if (f3 == 3'd0) begin
          case (instr_i[31:20])
            SYS_ECALL:  exp_sys = 5'b10000;
            SYS_EBREAK: exp_sys = 5'b01000;
            SYS_MRET:   exp_sys = 5'b00100;
            SYS_DRET:   exp_sys = 5'b00010;
            SYS_WFI:    exp_sys = 5'b00001;
            default:    bad = 1'b1;
          endcase
          if (rs1 != '0 || rd != '0) begin
            bad = 1'b1;
          end
        end else begin
          e_csr     = 1'b1;
          e_rf_we   = 1'b1;
          exp_wsel  = RF_WD_CSR;
          exp_ren_a = !f3[2];  // immediate forms carry uimm in the rs1 field
          case (f3[1:0])
            2'd1:    exp_csr_op = CSR_OP_WRITE;
            2'd2:    exp_csr_op = (rs1 == '0) ? CSR_OP_READ : CSR_OP_SET;
            2'd3:    exp_csr_op = (rs1 == '0) ? CSR_OP_READ : CSR_OP_CLEAR;
            default: bad = 1'b1;
          endcase
        end
      end
      default: known = 1'b0;
    endcase
    exp_illegal = illegal_c_i | bad | ~known;
    exp_side    = exp_illegal ? '0 : {e_rf_we, e_req, e_we, e_jump, e_jset, e_branch, e_csr};
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("ERROR %s: instr %08h expected %0h actual %0h", name, instr_i, expected, actual);
  endtask

  //////////////////////////////
  // assertions
  //////////////////////////////
  a_illegal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    illegal_insn_i == exp_illegal)
    else report_mismatch("illegal_insn", 32'(exp_illegal), 32'(illegal_insn_i));

  a_side_effects : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    side == exp_side)
    else report_mismatch("side_effects", 32'(exp_side), 32'(side));

  // unmasked outputs only mean something for legal words
  a_lsu_size : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exp_illegal |-> {data_type_i, data_sign_ext_i} == {exp_type, exp_sext})
    else report_mismatch("lsu_size", 32'({exp_type, exp_sext}),
                         32'({data_type_i, data_sign_ext_i}));

  a_muldiv : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exp_illegal |-> {md_op_i, md_signed_i} == {exp_md, exp_msign})
    else report_mismatch("muldiv", 32'({exp_md, exp_msign}), 32'({md_op_i, md_signed_i}));

  a_csr_op : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exp_illegal |-> {csr_op_i, wdata_sel_i} == {exp_csr_op, exp_wsel})
    else report_mismatch("csr_op", 32'({exp_csr_op, exp_wsel}), 32'({csr_op_i, wdata_sel_i}));

  a_rf_ren : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exp_illegal |-> {rf_ren_a_i, rf_ren_b_i} == {exp_ren_a, exp_ren_b})
    else report_mismatch("rf_ren", 32'({exp_ren_a, exp_ren_b}),
                         32'({rf_ren_a_i, rf_ren_b_i}));

  a_sys_flags : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exp_illegal |-> sys == exp_sys)
    else report_mismatch("sys_flags", 32'(exp_sys), 32'(sys));

  a_icache : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exp_illegal |-> icache_inval_i == exp_icache)
    else report_mismatch("icache_inval", 32'(exp_icache), 32'(icache_inval_i));

endmodule

// File: verification/tb_instr_decoder.sv
// testbench for the rv32im instruction decoder
// directed encodings, lfsr random words, timeout and closing report
module tb_instr_decoder
  import decoder_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 8;
  localparam int DIRECTED_WORDS = 148;
  localparam int RANDOM_WORDS   = 2000;
  // run length plus a fifth of slack
  localparam int TIMEOUT_CYCLES = (RESET_CYCLES + DIRECTED_WORDS + RANDOM_WORDS) * 6 / 5;

  logic               clk;
  logic               rst_n;
  logic               first_cycle;
  logic [INSTR_W-1:0] instr;
  logic               illegal_c;
  logic               illegal_insn, ebrk, mret, dret, ecall, wfi, jump_set, icache_inval;
  rf_wd_sel_e         rf_wdata_sel;
  logic               rf_we, rf_ren_a, rf_ren_b, csr_access;
  md_op_e             md_op;
  logic [1:0]         md_signed;
  csr_op_e            csr_op;
  logic               data_req, data_we, data_sext, jump_in_dec, branch_in_dec;
  logic [1:0]         data_type;
  int                 check_errors;
  int                 cycle_count;
  logic [31:0]        lfsr;

  opcode_e     op_list [11] = '{OPCODE_LOAD, OPCODE_MISC_MEM, OPCODE_OP_IMM, OPCODE_AUIPC,
                                OPCODE_STORE, OPCODE_OP, OPCODE_LUI, OPCODE_BRANCH,
                                OPCODE_JALR, OPCODE_JAL, OPCODE_SYSTEM};
  logic [11:0] sys_imm [5]  = '{SYS_ECALL, SYS_EBREAK, SYS_MRET, SYS_DRET, SYS_WFI};
  logic [6:0]  op_f7 [3]    = '{FUNCT7_MULDIV, FUNCT7_ALT, 7'h7f};

  instr_decoder instr_decoder_inst (
    .clk_i (clk), .rst_n_i (rst_n), .instr_first_cycle_i (first_cycle),
    .instr_rdata_i (instr), .illegal_c_insn_i (illegal_c),
    .illegal_insn_o (illegal_insn), .ebrk_insn_o (ebrk), .mret_insn_o (mret),
    .dret_insn_o (dret), .ecall_insn_o (ecall), .wfi_insn_o (wfi),
    .jump_set_o (jump_set), .icache_inval_o (icache_inval),
    .rf_wdata_sel_o (rf_wdata_sel), .rf_we_o (rf_we), .rf_ren_a_o (rf_ren_a),
    .rf_ren_b_o (rf_ren_b), .multdiv_operator_o (md_op),
    .multdiv_signed_mode_o (md_signed), .csr_access_o (csr_access),
    .csr_op_o (csr_op), .data_req_o (data_req), .data_we_o (data_we),
    .data_type_o (data_type), .data_sign_extension_o (data_sext),
    .jump_in_dec_o (jump_in_dec), .branch_in_dec_o (branch_in_dec)
  );

  decoder_checks decoder_checks_inst (
    .clk_i (clk), .rst_n_i (rst_n), .instr_i (instr), .first_cycle_i (first_cycle),
    .illegal_c_i (illegal_c), .illegal_insn_i (illegal_insn),
    .rf_we_i (rf_we), .data_req_i (data_req), .data_we_i (data_we),
    .jump_in_dec_i (jump_in_dec), .jump_set_i (jump_set),
    .branch_in_dec_i (branch_in_dec), .csr_access_i (csr_access),
    .rf_ren_a_i (rf_ren_a), .rf_ren_b_i (rf_ren_b),
    .ecall_i (ecall), .ebrk_i (ebrk), .mret_i (mret), .dret_i (dret), .wfi_i (wfi),
    .icache_inval_i (icache_inval), .data_type_i (data_type),
    .data_sign_ext_i (data_sext), .md_op_i (md_op), .md_signed_i (md_signed),
    .csr_op_i (csr_op), .wdata_sel_i (rf_wdata_sel), .err_count_o (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  task automatic drive(input logic [INSTR_W-1:0] word, input logic fc, input logic ic);
    @(negedge clk);
    instr       = word;
    first_cycle = fc;
    illegal_c   = ic;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_count);
    $display("closing report: %0d assertion errors, 1 timeout", check_errors);
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin
    logic [31:0] rnd_word;
    logic [31:0] r;
    logic [3:0]  op_idx;
    logic [3:0]  o;
    logic [3:0]  f;
    logic [1:0]  k;
    logic [2:0]  s;
    rst_n       = 1'b0;
    instr       = '0;  // illegal opcode, all outputs quiet
    first_cycle = 1'b0;
    illegal_c   = 1'b0;
    lfsr        = 32'hec63_342c;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // every opcode against every funct3
    for (o = 4'd0; o < 4'd11; o++) begin
      for (f = 4'd0; f < 4'd8; f++) begin
        drive({FUNCT7_BASE, 5'd2, 5'd1, f[2:0], 5'd4, op_list[o]}, f[0], 1'b0);
      end
    end
    // op funct7 variants, op-imm alt shifts
    for (f = 4'd0; f < 4'd8; f++) begin
      for (k = 2'd0; k < 2'd3; k++) begin
        drive({op_f7[k], 5'd2, 5'd1, f[2:0], 5'd4, OPCODE_OP}, 1'b0, 1'b0);
      end
      drive({FUNCT7_ALT, 5'd2, 5'd1, f[2:0], 5'd4, OPCODE_OP_IMM}, 1'b0, 1'b0);
    end
    for (s = 3'd0; s < 3'd5; s++) begin
      drive({sys_imm[s], 5'd0, 3'd0, 5'd0, OPCODE_SYSTEM}, 1'b0, 1'b0);
      drive({sys_imm[s], 5'd0, 3'd0, 5'd1, OPCODE_SYSTEM}, 1'b0, 1'b0);  // rd set
    end
    drive({12'h003, 5'd0, 3'd0, 5'd0, OPCODE_SYSTEM}, 1'b0, 1'b0);
    // csr forms with a zero rs1/uimm field
    for (f = 4'd1; f < 4'd8; f++) begin
      drive({12'h300, 5'd0, f[2:0], 5'd4, OPCODE_SYSTEM}, 1'b0, 1'b0);
    end
    for (f = 4'd0; f < 4'd2; f++) begin
      drive({20'h00010, 5'd1, OPCODE_JAL}, f[0], 1'b0);
      drive({12'h010, 5'd3, 3'd0, 5'd1, OPCODE_JALR}, f[0], 1'b0);
      drive({17'd0, 3'd1, 5'd0, OPCODE_MISC_MEM}, f[0], 1'b0);  // fence.i
    end
    drive({FUNCT7_BASE, 5'd2, 5'd1, 3'd0, 5'd4, OPCODE_OP}, 1'b0, 1'b1);
    drive({20'h00010, 5'd1, OPCODE_JAL}, 1'b1, 1'b1);
    drive(32'h0000_007f, 1'b0, 1'b0);
    drive(32'h0000_000b, 1'b0, 1'b0);

    // random words, half of them with a known opcode
    for (int i = 0; i < RANDOM_WORDS; i++) begin
      rnd_word = draw_bits(32);
      r = draw_bits(1);
      if (r[0]) begin
        r             = draw_bits(4);
        op_idx        = 4'(r % 11);
        rnd_word[6:0] = op_list[op_idx];
      end
      r = draw_bits(4);
      drive(rnd_word, r[0], &r[3:1]);
    end
    @(negedge clk);

    $display("closing report: %0d assertion errors, 0 timeouts", check_errors);
    if (check_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/alu_decoder.sv
// alu class decoder
// lui, auipc, op-imm and op, with the rv32m mult/div selection
module alu_decoder
  import decoder_pkg::*;
(
  input  logic [INSTR_W-1:0] instr_i,
  output logic               claim_o,
  output logic               illegal_o,
  output logic               rf_we_o,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,
  output md_op_e             md_op_o,
  output logic [1:0]         md_signed_mode_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    claim_o          = 1'b0;
    illegal_o        = 1'b0;
    rf_we_o          = 1'b0;
    rf_ren_a_o       = 1'b0;
    rf_ren_b_o       = 1'b0;
    md_op_o          = MD_OP_MULL;
    md_signed_mode_o = MD_SIGNED_NONE;

    unique case (opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin
        claim_o = 1'b1;
        rf_we_o = 1'b1;
      end
      OPCODE_OP_IMM: begin
        claim_o    = 1'b1;
        rf_we_o    = 1'b1;
        rf_ren_a_o = 1'b1;
        // shamt sits in [24:20], upper bits select the shift kind
        if (funct3 == 3'b001) begin
          illegal_o = (funct7 != FUNCT7_BASE);
        end else if (funct3 == 3'b101) begin
          illegal_o = (funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_ALT);
        end
      end
      OPCODE_OP: begin
        claim_o    = 1'b1;
        rf_we_o    = 1'b1;
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        unique case ({funct7, funct3})
          {FUNCT7_BASE, 3'b000}, {FUNCT7_ALT, 3'b000},   // add, sub
          {FUNCT7_BASE, 3'b001}, {FUNCT7_BASE, 3'b010},  // sll, slt
          {FUNCT7_BASE, 3'b011}, {FUNCT7_BASE, 3'b100},  // sltu, xor
          {FUNCT7_BASE, 3'b101}, {FUNCT7_ALT, 3'b101},   // srl, sra
          {FUNCT7_BASE, 3'b110}, {FUNCT7_BASE, 3'b111}: ; // or, and

          {FUNCT7_MULDIV, 3'b000}: md_op_o = MD_OP_MULL;  // mul
          {FUNCT7_MULDIV, 3'b001}: begin                  // mulh
            md_op_o          = MD_OP_MULH;
            md_signed_mode_o = MD_SIGNED_BOTH;
          end
          {FUNCT7_MULDIV, 3'b010}: begin                  // mulhsu
            md_op_o          = MD_OP_MULH;
            md_signed_mode_o = MD_SIGNED_MIXED;
          end
          {FUNCT7_MULDIV, 3'b011}: md_op_o = MD_OP_MULH;  // mulhu
          {FUNCT7_MULDIV, 3'b100}: begin                  // div
            md_op_o          = MD_OP_DIV;
            md_signed_mode_o = MD_SIGNED_BOTH;
          end
          {FUNCT7_MULDIV, 3'b101}: md_op_o = MD_OP_DIV;   // divu
          {FUNCT7_MULDIV, 3'b110}: begin                  // rem
            md_op_o          = MD_OP_REM;
            md_signed_mode_o = MD_SIGNED_BOTH;
          end
          {FUNCT7_MULDIV, 3'b111}: md_op_o = MD_OP_REM;   // remu
          default: illegal_o = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/csr_decoder.sv
// csr class decoder
// csrrw/s/c and immediate forms, with the zero-operand check
module csr_decoder
  import decoder_pkg::*;
(
  input  logic [INSTR_W-1:0] instr_i,
  output logic               claim_o,
  output logic               illegal_o,
  output logic               csr_access_o,
  output logic               rf_we_o,
  output logic               rf_ren_a_o,
  output rf_wd_sel_e         rf_wdata_sel_o,
  output csr_op_e            csr_op_o
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [REG_ADDR_W-1:0] rs1_uimm;  // rs1 or uimm[4:0]
  csr_op_e               csr_op;

  assign opcode   = opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign rs1_uimm = instr_i[19:15];

  assign claim_o        = (opcode == OPCODE_SYSTEM) && (funct3 != 3'b000);
  assign csr_access_o   = claim_o;
  assign rf_we_o        = claim_o;
  assign rf_ren_a_o     = claim_o & ~funct3[2];
  assign rf_wdata_sel_o = claim_o ? RF_WD_CSR : RF_WD_EX;

  always_comb begin
    illegal_o = 1'b0;
    csr_op    = CSR_OP_READ;
    if (claim_o) begin
      unique case (funct3[1:0])
        2'b01:   csr_op    = CSR_OP_WRITE;
        2'b10:   csr_op    = CSR_OP_SET;
        2'b11:   csr_op    = CSR_OP_CLEAR;
        default: illegal_o = 1'b1;  // funct3 = 4
      endcase
    end
  end

  //////////////////////////////
  // operand check
  //////////////////////////////
  // set/clear with a zero mask must not write the csr
  always_comb begin
    csr_op_o = csr_op;
    if ((csr_op == CSR_OP_SET || csr_op == CSR_OP_CLEAR) && rs1_uimm == '0) begin
      csr_op_o = CSR_OP_READ;
    end
  end

  always_comb begin : chk_access_claim
    assert (!csr_access_o || claim_o)
      else $error("csr_decoder: csr access on an unclaimed instruction");
  end

endmodule

// File: verilog/ctrl_flow_decoder.sv
// control-flow class decoder
// jal, jalr, branch, fence, fence.i and non-csr system instructions
module ctrl_flow_decoder
  import decoder_pkg::*;
(
  input  logic [INSTR_W-1:0] instr_i,
  input  logic               first_cycle_i,
  output logic               claim_o,
  output logic               illegal_o,
  output logic               jump_in_dec_o,
  output logic               jump_set_o,
  output logic               branch_in_dec_o,
  output logic               icache_inval_o,
  output logic               rf_we_o,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,
  output logic               ecall_o,
  output logic               ebrk_o,
  output logic               mret_o,
  output logic               dret_o,
  output logic               wfi_o
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [11:0]           imm12;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rd;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign imm12  = instr_i[31:20];
  assign rs1    = instr_i[19:15];
  assign rd     = instr_i[11:7];

  always_comb begin
    claim_o         = 1'b0;
    illegal_o       = 1'b0;
    jump_in_dec_o   = 1'b0;
    jump_set_o      = 1'b0;
    branch_in_dec_o = 1'b0;
    icache_inval_o  = 1'b0;
    rf_we_o         = 1'b0;
    rf_ren_a_o      = 1'b0;
    rf_ren_b_o      = 1'b0;
    ecall_o         = 1'b0;
    ebrk_o          = 1'b0;
    mret_o          = 1'b0;
    dret_o          = 1'b0;
    wfi_o           = 1'b0;

    unique case (opcode)
      OPCODE_JAL, OPCODE_JALR: begin
        claim_o       = 1'b1;
        jump_in_dec_o = 1'b1;
        jump_set_o    = first_cycle_i;  // target goes out in the first cycle
        rf_we_o       = 1'b1;           // link written in both cycles
        if (opcode == OPCODE_JALR) begin
          rf_ren_a_o = 1'b1;
          illegal_o  = (funct3 != 3'b000);
        end
      end
      OPCODE_BRANCH: begin
        claim_o         = 1'b1;
        branch_in_dec_o = 1'b1;
        rf_ren_a_o      = 1'b1;
        rf_ren_b_o      = 1'b1;
        illegal_o       = (funct3[2:1] == 2'b01);  // funct3 2 and 3 unused
      end
      OPCODE_MISC_MEM: begin
        claim_o = 1'b1;
        unique case (funct3)
          3'b000: ;  // fence, memory is already in order
          3'b001: begin
            // fence.i as a jump to pc+4 flushes the fetch side
            jump_in_dec_o  = 1'b1;
            jump_set_o     = first_cycle_i;
            icache_inval_o = first_cycle_i;
          end
          default: illegal_o = 1'b1;
        endcase
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin  // csr forms belong to csr_decoder
          claim_o = 1'b1;
          unique case (imm12)
            SYS_ECALL:  ecall_o = 1'b1;
            SYS_EBREAK: ebrk_o  = 1'b1;
            SYS_MRET:   mret_o  = 1'b1;
            SYS_DRET:   dret_o  = 1'b1;
            SYS_WFI:    wfi_o   = 1'b1;
            default:    illegal_o = 1'b1;
          endcase
          if (rs1 != '0 || rd != '0) begin
            illegal_o = 1'b1;
          end
        end
      end
      default: ;
    endcase
  end

  always_comb begin : chk_sys_flags
    assert ($onehot0({ecall_o, ebrk_o, mret_o, dret_o, wfi_o}))
      else $error("ctrl_flow_decoder: more than one system flag");
  end

endmodule

// File: verilog/decoder_pkg.sv
// shared types and constants for the rv32im decoder
// opcode, csr, mult/div and write-select enums
// lsu size, signed mode, funct7 and system immediate codes
package decoder_pkg;

  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [1:0] {
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  typedef enum logic {
    RF_WD_EX,   // alu or mult/div result
    RF_WD_CSR   // csr read data
  } rf_wd_sel_e;

  //////////////////////////////
  // field codes
  //////////////////////////////
  localparam logic [1:0] DATA_TYPE_WORD = 2'd0;
  localparam logic [1:0] DATA_TYPE_HALF = 2'd1;
  localparam logic [1:0] DATA_TYPE_BYTE = 2'd2;

  localparam logic [1:0] MD_SIGNED_NONE  = 2'd0;
  localparam logic [1:0] MD_SIGNED_MIXED = 2'd1;  // rs1 signed, rs2 unsigned
  localparam logic [1:0] MD_SIGNED_BOTH  = 2'd3;

  localparam logic [6:0] FUNCT7_BASE   = 7'h00;
  localparam logic [6:0] FUNCT7_ALT    = 7'h20;  // sub, sra, srai
  localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

  // instr[31:20] of the funct3 = 0 system instructions
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;
  localparam logic [11:0] SYS_DRET   = 12'h7b2;
  localparam logic [11:0] SYS_WFI    = 12'h105;

endpackage

// File: verilog/instr_decoder.sv
// rv32im instruction decoder top level
// fans the instruction out to four class decoders, merges the results
// and masks side effects of illegal instructions
module instr_decoder
  import decoder_pkg::*;
(
  input  logic               clk_i,                 // assertion sampling only
  input  logic               rst_n_i,
  input  logic               instr_first_cycle_i,
  input  logic [INSTR_W-1:0] instr_rdata_i,
  input  logic               illegal_c_insn_i,      // compressed decode failed
  output logic               illegal_insn_o,
  output logic               ebrk_insn_o,
  output logic               mret_insn_o,
  output logic               dret_insn_o,
  output logic               ecall_insn_o,
  output logic               wfi_insn_o,
  output logic               jump_set_o,
  output logic               icache_inval_o,
  output rf_wd_sel_e         rf_wdata_sel_o,
  output logic               rf_we_o,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,
  output md_op_e             multdiv_operator_o,
  output logic [1:0]         multdiv_signed_mode_o,
  output logic               csr_access_o,
  output csr_op_e            csr_op_o,
  output logic               data_req_o,
  output logic               data_we_o,
  output logic [1:0]         data_type_o,
  output logic               data_sign_extension_o,
  output logic               jump_in_dec_o,
  output logic               branch_in_dec_o
);

  logic cf_claim, cf_illegal, cf_jump_in_dec, cf_jump_set, cf_branch, cf_rf_we;
  logic cf_ren_a, cf_ren_b;
  logic lsu_claim, lsu_illegal, lsu_req, lsu_we, lsu_rf_we, lsu_ren_a, lsu_ren_b;
  logic alu_claim, alu_illegal, alu_rf_we, alu_ren_a, alu_ren_b;
  logic csr_claim, csr_illegal, csr_access, csr_rf_we, csr_ren_a;
  logic illegal_insn;

  ctrl_flow_decoder ctrl_flow_decoder_inst (
    .instr_i (instr_rdata_i), .first_cycle_i (instr_first_cycle_i),
    .claim_o (cf_claim), .illegal_o (cf_illegal),
    .jump_in_dec_o (cf_jump_in_dec), .jump_set_o (cf_jump_set),
    .branch_in_dec_o (cf_branch), .icache_inval_o (icache_inval_o),
    .rf_we_o (cf_rf_we), .rf_ren_a_o (cf_ren_a), .rf_ren_b_o (cf_ren_b),
    .ecall_o (ecall_insn_o), .ebrk_o (ebrk_insn_o), .mret_o (mret_insn_o),
    .dret_o (dret_insn_o), .wfi_o (wfi_insn_o)
  );

  lsu_decoder lsu_decoder_inst (
    .instr_i (instr_rdata_i), .claim_o (lsu_claim), .illegal_o (lsu_illegal),
    .data_req_o (lsu_req), .data_we_o (lsu_we), .data_type_o (data_type_o),
    .data_sign_ext_o (data_sign_extension_o), .rf_ren_a_o (lsu_ren_a),
    .rf_ren_b_o (lsu_ren_b), .rf_we_o (lsu_rf_we)
  );

  alu_decoder alu_decoder_inst (
    .instr_i (instr_rdata_i), .claim_o (alu_claim), .illegal_o (alu_illegal),
    .rf_we_o (alu_rf_we), .rf_ren_a_o (alu_ren_a), .rf_ren_b_o (alu_ren_b),
    .md_op_o (multdiv_operator_o), .md_signed_mode_o (multdiv_signed_mode_o)
  );

  csr_decoder csr_decoder_inst (
    .instr_i (instr_rdata_i), .claim_o (csr_claim), .illegal_o (csr_illegal),
    .csr_access_o (csr_access), .rf_we_o (csr_rf_we), .rf_ren_a_o (csr_ren_a),
    .rf_wdata_sel_o (rf_wdata_sel_o), .csr_op_o (csr_op_o)
  );

  //////////////////////////////
  // merge and mask
  //////////////////////////////
  assign illegal_insn = illegal_c_insn_i | cf_illegal | lsu_illegal | alu_illegal |
                        csr_illegal | ~(cf_claim | lsu_claim | alu_claim | csr_claim);
  assign illegal_insn_o = illegal_insn;

  assign rf_ren_a_o = cf_ren_a | lsu_ren_a | alu_ren_a | csr_ren_a;
  assign rf_ren_b_o = cf_ren_b | lsu_ren_b | alu_ren_b;

  // nothing of an illegal instruction may reach rf, lsu, csrs or pc
  assign rf_we_o         = ~illegal_insn & (cf_rf_we | lsu_rf_we | alu_rf_we | csr_rf_we);
  assign data_req_o      = ~illegal_insn & lsu_req;
  assign data_we_o       = ~illegal_insn & lsu_we;
  assign jump_in_dec_o   = ~illegal_insn & cf_jump_in_dec;
  assign jump_set_o      = ~illegal_insn & cf_jump_set;
  assign branch_in_dec_o = ~illegal_insn & cf_branch;
  assign csr_access_o    = ~illegal_insn & csr_access;

  a_one_claim : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({cf_claim, lsu_claim, alu_claim, csr_claim}))
    else $error("instr_decoder: two class decoders claim one instruction");

  a_illegal_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    illegal_insn_o |-> !(rf_we_o || data_req_o || data_we_o || jump_in_dec_o ||
                         jump_set_o || branch_in_dec_o || csr_access_o))
    else $error("instr_decoder: side effect on an illegal instruction");

endmodule

// File: verilog/lsu_decoder.sv
// load/store class decoder
// request, write, access size and sign extension
module lsu_decoder
  import decoder_pkg::*;
(
  input  logic [INSTR_W-1:0] instr_i,
  output logic               claim_o,
  output logic               illegal_o,
  output logic               data_req_o,
  output logic               data_we_o,
  output logic [1:0]         data_type_o,
  output logic               data_sign_ext_o,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,
  output logic               rf_we_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       is_load;
  logic       is_store;

  assign opcode   = opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign is_load  = (opcode == OPCODE_LOAD);
  assign is_store = (opcode == OPCODE_STORE);
  assign claim_o  = is_load | is_store;

  always_comb begin
    illegal_o       = 1'b0;
    data_type_o     = DATA_TYPE_WORD;
    data_req_o      = claim_o;
    rf_ren_a_o      = claim_o;            // base address
    data_we_o       = is_store;
    rf_ren_b_o      = is_store;           // store data
    rf_we_o         = is_load;
    data_sign_ext_o = is_load & ~funct3[2];

    if (claim_o) begin
      unique case (funct3[1:0])
        2'b00:   data_type_o = DATA_TYPE_BYTE;
        2'b01:   data_type_o = DATA_TYPE_HALF;
        2'b10:   data_type_o = DATA_TYPE_WORD;
        default: illegal_o   = 1'b1;
      endcase
      // no unsigned stores, and no lwu on rv32
      if (is_store && funct3[2]) illegal_o = 1'b1;
      if (is_load && funct3 == 3'b110) illegal_o = 1'b1;
    end
  end

  always_comb begin : chk_we_req
    assert (!data_we_o || data_req_o)
      else $error("lsu_decoder: write without request");
  end

endmodule
